// File: dv/tb_sa_top.sv
`timescale 1ns/1ps

module tb_sa_top
    import sa_array_pkg::*;
    import sa_cfg_pkg::*;
();

    localparam int NUM_JOBS     = 20;
    localparam int MAX_DEPTH    = 40;
    localparam int FEED_TIMEOUT = 1000;
    localparam int DONE_TIMEOUT = 200;
    localparam int OUT_MAX      = 2 ** (OUT_WIDTH - 1) - 1;
    localparam int OUT_MIN      = -(2 ** (OUT_WIDTH - 1));
    localparam logic [REG_WIDTH-1:0] STAT_BUSY = REG_WIDTH'(1) << STATUS_BUSY_BIT;
    localparam logic [REG_WIDTH-1:0] STAT_DONE = REG_WIDTH'(1) << STATUS_DONE_BIT;

    logic                             clk;
    logic                             rst_n;
    sa_reg_addr_t                     reg_addr;
    logic                             reg_wr;
    logic                             reg_rd;
    logic [REG_WIDTH-1:0]             reg_wdata;
    logic [REG_WIDTH-1:0]             reg_rdata;
    logic                             data_rdy_in;
    logic [ARRAY_SIZE*DATA_WIDTH-1:0] w_vec;
    logic [ARRAY_SIZE*DATA_WIDTH-1:0] i_vec;
    logic                             out_valid;
    logic [ADDR_WIDTH-1:0]            out_addr;
    logic signed [OUT_WIDTH-1:0]      out_data;
    logic                             busy;
    logic                             done;

    // jobs are stored so the bubble pass replays the same operands
    int                               job_depth [NUM_JOBS];
    logic [SHIFT_WIDTH-1:0]           job_shift [NUM_JOBS];
    logic [ADDR_WIDTH-1:0]            job_base  [NUM_JOBS];
    logic [ARRAY_SIZE*DATA_WIDTH-1:0] w_mem     [NUM_JOBS][MAX_DEPTH];
    logic [ARRAY_SIZE*DATA_WIDTH-1:0] i_mem     [NUM_JOBS][MAX_DEPTH];

    logic [ADDR_WIDTH-1:0]            exp_addr   [NUM_PE];
    logic signed [OUT_WIDTH-1:0]      exp_data   [NUM_PE];
    logic [ADDR_WIDTH-1:0]            got_addr_q [$];
    logic signed [OUT_WIDTH-1:0]      got_data_q [$];

    int          mismatch_count = 0;
    int          fail_count     = 0;
    int          burst_count    = 0;
    logic        prev_valid     = 1'b0;
    bit          aborted        = 1'b0;
    int unsigned seed_val;

    sa_top sa_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_addr    (reg_addr),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .data_rdy_in (data_rdy_in),
        .w_vec       (w_vec),
        .i_vec       (i_vec),
        .out_valid   (out_valid),
        .out_addr    (out_addr),
        .out_data    (out_data),
        .busy        (busy),
        .done        (done)
    );

    always #5 clk = ~clk;

    // results are sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                if (!prev_valid) begin
                    burst_count++;
                end
                got_addr_q.push_back(out_addr);
                got_data_q.push_back(out_data);
            end else if (prev_valid && (busy || !done)) begin
                $display("busy or done did not change in the cycle after the last result");
                fail_count++;
            end
            prev_valid = out_valid;
        end
    end

    task automatic check_result(input int idx, input logic [ADDR_WIDTH-1:0] exp_a,
                                input logic [ADDR_WIDTH-1:0] got_a,
                                input logic signed [OUT_WIDTH-1:0] exp_d,
                                input logic signed [OUT_WIDTH-1:0] got_d);
        if (got_a !== exp_a) begin
            $display("mismatch out_addr[%0d]: expected 0x%02h, got 0x%02h", idx, exp_a, got_a);
            mismatch_count++;
        end
        if (got_d !== exp_d) begin
            $display("mismatch out_data[%0d]: expected 0x%02h, got 0x%02h", idx, exp_d, got_d);
            mismatch_count++;
        end
    endtask

    task automatic check_reg(input string what, input logic [REG_WIDTH-1:0] expected,
                             input logic [REG_WIDTH-1:0] got);
        if (got !== expected) begin
            $display("mismatch reg_rdata (%s): expected 0x%02h, got 0x%02h", what, expected, got);
            mismatch_count++;
        end
    endtask

    task automatic write_reg(input sa_reg_addr_t addr, input logic [REG_WIDTH-1:0] data);
        @(negedge clk);
        reg_addr  = addr;
        reg_wdata = data;
        reg_wr    = 1'b1;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    // read data is registered, so it is taken one cycle after the strobe
    task automatic read_reg(input sa_reg_addr_t addr, output logic [REG_WIDTH-1:0] data);
        @(negedge clk);
        reg_addr = addr;
        reg_rd   = 1'b1;
        @(negedge clk);
        reg_rd = 1'b0;
        data   = reg_rdata;
    endtask

    function automatic int lane(input logic [ARRAY_SIZE*DATA_WIDTH-1:0] vec, input int l);
        logic signed [DATA_WIDTH-1:0] v;
        v = vec[l*DATA_WIDTH +: DATA_WIDTH];
        return int'(v);
    endfunction

    // reference model of dot products with arithmetic shift and saturation
    function automatic void build_expected(input int j);
        int sum;
        int shifted;
        int idx;
        for (int r = 0; r < ARRAY_SIZE; r++) begin
            for (int c = 0; c < ARRAY_SIZE; c++) begin
                sum = 0;
                for (int k = 0; k < job_depth[j]; k++) begin
                    sum += lane(w_mem[j][k], r) * lane(i_mem[j][k], c);
                end
                shifted = sum >>> job_shift[j];
                if (shifted > OUT_MAX) begin
                    shifted = OUT_MAX;
                end else if (shifted < OUT_MIN) begin
                    shifted = OUT_MIN;
                end
                idx           = r * ARRAY_SIZE + c;
                exp_data[idx] = OUT_WIDTH'(shifted);
                exp_addr[idx] = ADDR_WIDTH'((int'(job_base[j]) + idx) % 256);
            end
        end
    endfunction

    task automatic make_jobs();
        for (int j = 0; j < NUM_JOBS; j++) begin
            job_depth[j] = 1 + int'($urandom % MAX_DEPTH);
            job_shift[j] = SHIFT_WIDTH'($urandom % 16);
            job_base[j]  = ADDR_WIDTH'($urandom % 256);
            // every lane spans the full byte range including the extremes
            for (int k = 0; k < MAX_DEPTH; k++) begin
                w_mem[j][k] = $urandom;
                i_mem[j][k] = $urandom;
            end
        end
    endtask

    task automatic register_access_test();
        logic [REG_WIDTH-1:0] rd;
        read_reg(REG_STATUS, rd);
        check_reg("status after reset", 8'h00, rd);
        write_reg(REG_DEPTH, 8'h5a);
        write_reg(REG_SHIFT, 8'hf3);
        write_reg(REG_OUT_BASE, 8'hc7);
        read_reg(REG_DEPTH, rd);
        check_reg("depth", 8'h5a, rd);
        // only the low four shift bits are kept
        read_reg(REG_SHIFT, rd);
        check_reg("shift", 8'h03, rd);
        read_reg(REG_OUT_BASE, rd);
        check_reg("out_base", 8'hc7, rd);
        // every ctrl bit but start is set, and none of them reads back
        write_reg(REG_CTRL, 8'hfe);
        read_reg(REG_CTRL, rd);
        check_reg("ctrl", 8'h00, rd);
    endtask

    task automatic run_job(input int j, input bit gaps, input bit intrude);
        logic [REG_WIDTH-1:0] rd;
        int                   beat;
        int                   cycles;
        build_expected(j);
        got_addr_q.delete();
        got_data_q.delete();
        burst_count = 0;

        write_reg(REG_DEPTH, REG_WIDTH'(job_depth[j]));
        write_reg(REG_SHIFT, REG_WIDTH'(job_shift[j]));
        write_reg(REG_OUT_BASE, job_base[j]);
        write_reg(REG_CTRL, REG_WIDTH'(1) << CTRL_START_BIT);
        // done of the previous job is gone once the new one starts
        read_reg(REG_STATUS, rd);
        check_reg("status while busy", STAT_BUSY, rd);

        beat   = 0;
        cycles = 0;
        while (beat < job_depth[j] && cycles < FEED_TIMEOUT) begin
            @(negedge clk);
            if (gaps && ($urandom % 100) < 40) begin
                // bubble with junk on the lanes
                data_rdy_in = 1'b0;
                w_vec       = $urandom;
                i_vec       = $urandom;
            end else begin
                data_rdy_in = 1'b1;
                w_vec       = w_mem[j][beat];
                i_vec       = i_mem[j][beat];
                beat++;
            end
            cycles++;
        end
        @(negedge clk);
        data_rdy_in = 1'b0;
        if (beat < job_depth[j]) begin
            $display("job %0d timed out while feeding operand beats", j);
            fail_count++;
            aborted = 1'b1;
            return;
        end

        // array is flushing, so all of these must be ignored
        if (intrude) begin
            write_reg(REG_CTRL, REG_WIDTH'(1) << CTRL_START_BIT);
            write_reg(REG_SHIFT, REG_WIDTH'(~job_shift[j]));
            write_reg(REG_OUT_BASE, ~job_base[j]);
        end

        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("job %0d timed out waiting for done", j);
            fail_count++;
            aborted = 1'b1;
            return;
        end

        if (got_data_q.size() != NUM_PE) begin
            $display("job %0d emitted %0d results instead of %0d", j, got_data_q.size(), NUM_PE);
            fail_count++;
        end
        if (burst_count != 1) begin
            $display("job %0d results were not one unbroken burst", j);
            fail_count++;
        end
        for (int n = 0; n < NUM_PE && n < got_data_q.size(); n++) begin
            check_result(n, exp_addr[n], got_addr_q[n], exp_data[n], got_data_q[n]);
        end

        read_reg(REG_STATUS, rd);
        check_reg("status after job", STAT_DONE, rd);
        read_reg(REG_SHIFT, rd);
        check_reg("shift after job", REG_WIDTH'(job_shift[j]), rd);
        read_reg(REG_OUT_BASE, rd);
        check_reg("out_base after job", job_base[j], rd);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        reg_addr    = REG_DEPTH;
        reg_wr      = 1'b0;
        reg_rd      = 1'b0;
        reg_wdata   = '0;
        data_rdy_in = 1'b0;
        w_vec       = '0;
        i_vec       = '0;
        seed_val    = $urandom(32'h7f1e);
        make_jobs();

        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        register_access_test();
        // pass 0 streams every cycle, pass 1 inserts bubbles
        for (int pass = 0; pass < 2; pass++) begin
            for (int j = 0; j < NUM_JOBS && !aborted; j++) begin
                run_job(j, pass == 1, ((j + pass) % 2) == 1);
            end
        end
        repeat (4) @(negedge clk);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/sa_array_pkg.sv
package sa_array_pkg;

    // grid geometry
    localparam int ARRAY_SIZE = 4;
    localparam int NUM_PE     = ARRAY_SIZE * ARRAY_SIZE;
    localparam int IDX_WIDTH  = $clog2(NUM_PE);

    // operand lanes and accumulators are signed
    localparam int DATA_WIDTH = 8;
    localparam int ACC_WIDTH  = 24;
    localparam int OUT_WIDTH  = 8;

    // last accepted beat to final sum in the bottom right PE
    localparam int FLUSH_CYCLES = 3 * ARRAY_SIZE - 1;
    localparam int FLUSH_WIDTH  = $clog2(FLUSH_CYCLES + 1);

    // sequencer states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        FEED  = 2'd1,
        FLUSH = 2'd2,
        DRAIN = 2'd3
    } sa_state_t;

endpackage

// File: hdl/sa_cfg_pkg.sv
package sa_cfg_pkg;

    // host register port
    localparam int REG_WIDTH = 8;

    // config field widths
    localparam int DEPTH_WIDTH = 8;
    localparam int SHIFT_WIDTH = 4;
    localparam int ADDR_WIDTH  = 8;

    // bit positions inside ctrl and status
    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    typedef enum logic [2:0] {
        REG_DEPTH    = 3'd0,
        REG_SHIFT    = 3'd1,
        REG_OUT_BASE = 3'd2,
        REG_CTRL     = 3'd3,
        REG_STATUS   = 3'd4
    } sa_reg_addr_t;

endpackage

// File: hdl/sa_controller.sv
`timescale 1ns/1ps

module sa_controller
    import sa_array_pkg::*;
    import sa_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [DEPTH_WIDTH-1:0] depth,
    input  logic                   data_rdy_in,
    input  logic                   drain_busy,
    output logic                   feed_en,
    output logic                   beat_valid,
    output logic                   clr_acc,
    output logic                   capture,
    output logic                   busy,
    output logic                   done_set
);

    sa_state_t               state;
    sa_state_t               state_nxt;
    logic [DEPTH_WIDTH-1:0]  beat_cnt;
    logic [DEPTH_WIDTH-1:0]  depth_eff;
    logic [FLUSH_WIDTH-1:0]  flush_cnt;
    logic                    last_beat;
    logic                    flush_end;

    // a depth of zero runs a single beat
    assign depth_eff = (depth == '0) ? DEPTH_WIDTH'(1) : depth;

    assign feed_en    = (state == FEED);
    assign beat_valid = feed_en && data_rdy_in;
    assign last_beat  = beat_valid && (beat_cnt == depth_eff - 1'b1);
    assign flush_end  = (state == FLUSH) && (flush_cnt == FLUSH_WIDTH'(1));

    assign clr_acc  = (state == IDLE) && start;
    assign capture  = flush_end;
    assign busy     = (state != IDLE);
    assign done_set = (state == DRAIN) && !drain_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = FEED;
                end
            end
            FEED: begin
                if (last_beat) begin
                    state_nxt = FLUSH;
                end
            end
            FLUSH: begin
                if (flush_end) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                // drain_busy drops on the last result
                if (!drain_busy) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // accepted beats of the current job
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (clr_acc) begin
            beat_cnt <= '0;
        end else if (beat_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // loaded on the last beat and counted down through FLUSH
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flush_cnt <= '0;
        end else if (last_beat) begin
            flush_cnt <= FLUSH_WIDTH'(FLUSH_CYCLES);
        end else if (state == FLUSH) begin
            flush_cnt <= flush_cnt - 1'b1;
        end
    end

    // depth must hold still while beats are being counted
    a_beat_within_depth: assert property (
        @(posedge clk) disable iff (!rst_n) feed_en |-> (beat_cnt < depth_eff)
    );

    // the drain only runs while the sequencer waits in DRAIN
    a_drain_in_drain_state: assert property (
        @(posedge clk) disable iff (!rst_n) drain_busy |-> (state == DRAIN)
    );

endmodule

// File: hdl/sa_drain.sv
`timescale 1ns/1ps

module sa_drain
    import sa_array_pkg::*;
    import sa_cfg_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          capture,
    input  logic [NUM_PE*ACC_WIDTH-1:0]   acc_flat,
    input  logic [SHIFT_WIDTH-1:0]        shift,
    input  logic [ADDR_WIDTH-1:0]         out_base,
    output logic                          out_valid,
    output logic [ADDR_WIDTH-1:0]         out_addr,
    output logic signed [OUT_WIDTH-1:0]   out_data,
    output logic                          drain_busy
);

    logic [NUM_PE*ACC_WIDTH-1:0]  snap;
    logic [IDX_WIDTH-1:0]         idx;
    logic                         active;
    logic signed [ACC_WIDTH-1:0]  elem;
    logic signed [ACC_WIDTH-1:0]  shifted;
    logic                         in_range;

    // snapshot frees the array for the next job
    always_ff @(posedge clk) begin
        if (capture) begin
            snap <= acc_flat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (capture) begin
            active <= 1'b1;
            idx    <= '0;
        end else if (active) begin
            idx <= idx + 1'b1;
            if (idx == IDX_WIDTH'(NUM_PE - 1)) begin
                active <= 1'b0;
            end
        end
    end

    // row-major walk, index = r*ARRAY_SIZE + c
    assign elem    = snap[idx*ACC_WIDTH +: ACC_WIDTH];
    assign shifted = elem >>> shift;

    // fits in OUT_WIDTH when all bits above the result sign agree
    assign in_range = (&shifted[ACC_WIDTH-1:OUT_WIDTH-1]) ||
                      (~|shifted[ACC_WIDTH-1:OUT_WIDTH-1]);

    always_comb begin
        if (in_range) begin
            out_data = shifted[OUT_WIDTH-1:0];
        end else if (shifted[ACC_WIDTH-1]) begin
            out_data = {1'b1, {(OUT_WIDTH-1){1'b0}}};
        end else begin
            out_data = {1'b0, {(OUT_WIDTH-1){1'b1}}};
        end
    end

    assign out_valid = active;
    assign out_addr  = out_base + ADDR_WIDTH'(idx);

    // low already on the last result so the sequencer finishes one cycle later
    assign drain_busy = active && (idx != IDX_WIDTH'(NUM_PE - 1));

    a_no_capture_while_draining: assert property (
        @(posedge clk) disable iff (!rst_n) capture |-> !active
    );

endmodule

// File: hdl/sa_pe.sv
`timescale 1ns/1ps

module sa_pe
    import sa_array_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         clr_acc,
    input  logic signed [DATA_WIDTH-1:0] a_in,
    input  logic signed [DATA_WIDTH-1:0] b_in,
    input  logic                         v_in,
    output logic signed [DATA_WIDTH-1:0] a_out,
    output logic signed [DATA_WIDTH-1:0] b_out,
    output logic                         v_out,
    output logic signed [ACC_WIDTH-1:0]  acc
);

    logic signed [2*DATA_WIDTH-1:0] prod;

    assign prod = a_in * b_in;

    // operands hop one cell per cycle
    always_ff @(posedge clk) begin
        a_out <= a_in;
        b_out <= b_in;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_out <= 1'b0;
            acc   <= '0;
        end else if (clr_acc) begin
            v_out <= 1'b0;
            acc   <= '0;
        end else begin
            v_out <= v_in;
            if (v_in) begin
                acc <= acc + prod;
            end
        end
    end

    // a clear must never swallow a live operand pair
    a_no_valid_on_clear: assert property (
        @(posedge clk) disable iff (!rst_n) clr_acc |-> !v_in
    );

endmodule

// File: hdl/sa_reg_file.sv
`timescale 1ns/1ps

module sa_reg_file
    import sa_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  sa_reg_addr_t           reg_addr,
    input  logic                   reg_wr,
    input  logic                   reg_rd,
    input  logic [REG_WIDTH-1:0]   reg_wdata,
    output logic [REG_WIDTH-1:0]   reg_rdata,
    input  logic                   busy,
    input  logic                   done_set,
    output logic                   start,
    output logic [DEPTH_WIDTH-1:0] depth,
    output logic [SHIFT_WIDTH-1:0] shift,
    output logic [ADDR_WIDTH-1:0]  out_base,
    output logic                   done
);

    logic                 cfg_wr;
    logic [REG_WIDTH-1:0] status;

    // config is frozen while a job runs
    assign cfg_wr = reg_wr && !busy;

    // start is a pulse straight off the write strobe
    assign start = reg_wr && (reg_addr == REG_CTRL) && reg_wdata[CTRL_START_BIT] && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            depth    <= '0;
            shift    <= '0;
            out_base <= '0;
        end else if (cfg_wr) begin
            case (reg_addr)
                REG_DEPTH:    depth    <= reg_wdata[DEPTH_WIDTH-1:0];
                REG_SHIFT:    shift    <= reg_wdata[SHIFT_WIDTH-1:0];
                REG_OUT_BASE: out_base <= reg_wdata[ADDR_WIDTH-1:0];
                default:      ;
            endcase
        end
    end

    // done is sticky until the next start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b0;
        end else if (done_set) begin
            done <= 1'b1;
        end
    end

    always_comb begin
        status                  = '0;
        status[STATUS_BUSY_BIT] = busy;
        status[STATUS_DONE_BIT] = done;
    end

    // read data holds until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            case (reg_addr)
                REG_DEPTH:    reg_rdata <= REG_WIDTH'(depth);
                REG_SHIFT:    reg_rdata <= REG_WIDTH'(shift);
                REG_OUT_BASE: reg_rdata <= REG_WIDTH'(out_base);
                REG_STATUS:   reg_rdata <= status;
                default:      reg_rdata <= '0;
            endcase
        end
    end

    // an accepted start always launches the sequencer on the next cycle
    a_start_launches: assert property (
        @(posedge clk) disable iff (!rst_n) start |=> busy
    );

endmodule

// File: hdl/sa_skew_feeder.sv
`timescale 1ns/1ps

module sa_skew_feeder
    import sa_array_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clr_acc,
    input  logic                             beat_valid,
    input  logic [ARRAY_SIZE*DATA_WIDTH-1:0] w_vec,
    input  logic [ARRAY_SIZE*DATA_WIDTH-1:0] i_vec,
    output logic [ARRAY_SIZE*DATA_WIDTH-1:0] w_row,
    output logic [ARRAY_SIZE-1:0]            w_row_valid,
    output logic [ARRAY_SIZE*DATA_WIDTH-1:0] i_col,
    output logic [ARRAY_SIZE-1:0]            i_col_valid
);

    for (genvar l = 0; l < ARRAY_SIZE; l++) begin : lane
        if (l == 0) begin : g_direct
            // lane 0 enters the grid without delay
            assign w_row[0 +: DATA_WIDTH] = w_vec[0 +: DATA_WIDTH];
            assign i_col[0 +: DATA_WIDTH] = i_vec[0 +: DATA_WIDTH];
            assign w_row_valid[0]         = beat_valid;
            assign i_col_valid[0]         = beat_valid;
        end else begin : g_delay
            logic [DATA_WIDTH-1:0] w_sr [l];
            logic [DATA_WIDTH-1:0] i_sr [l];
            logic [l-1:0]          v_sr;

            always_ff @(posedge clk) begin
                w_sr[0] <= w_vec[l*DATA_WIDTH +: DATA_WIDTH];
                i_sr[0] <= i_vec[l*DATA_WIDTH +: DATA_WIDTH];
                for (int k = 1; k < l; k++) begin
                    w_sr[k] <= w_sr[k-1];
                    i_sr[k] <= i_sr[k-1];
                end
            end

            // weight and input share one skew, so one valid line per lane
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    v_sr <= '0;
                end else if (clr_acc) begin
                    v_sr <= '0;
                end else begin
                    v_sr[0] <= beat_valid;
                    for (int k = 1; k < l; k++) begin
                        v_sr[k] <= v_sr[k-1];
                    end
                end
            end

            assign w_row[l*DATA_WIDTH +: DATA_WIDTH] = w_sr[l-1];
            assign i_col[l*DATA_WIDTH +: DATA_WIDTH] = i_sr[l-1];
            assign w_row_valid[l]                    = v_sr[l-1];
            assign i_col_valid[l]                    = v_sr[l-1];
        end
    end

endmodule

// File: hdl/sa_top.sv
`timescale 1ns/1ps

module sa_top
    import sa_array_pkg::*;
    import sa_cfg_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  sa_reg_addr_t                     reg_addr,
    input  logic                             reg_wr,
    input  logic                             reg_rd,
    input  logic [REG_WIDTH-1:0]             reg_wdata,
    output logic [REG_WIDTH-1:0]             reg_rdata,
    input  logic                             data_rdy_in,
    input  logic [ARRAY_SIZE*DATA_WIDTH-1:0] w_vec,
    input  logic [ARRAY_SIZE*DATA_WIDTH-1:0] i_vec,
    output logic                             out_valid,
    output logic [ADDR_WIDTH-1:0]            out_addr,
    output logic signed [OUT_WIDTH-1:0]      out_data,
    output logic                             busy,
    output logic                             done
);

    logic                             start;
    logic [DEPTH_WIDTH-1:0]           depth;
    logic [SHIFT_WIDTH-1:0]           shift;
    logic [ADDR_WIDTH-1:0]            out_base;
    logic                             done_set;
    logic                             beat_valid;
    logic                             clr_acc;
    logic                             capture;
    logic                             drain_busy;
    logic [ARRAY_SIZE*DATA_WIDTH-1:0] w_row;
    logic [ARRAY_SIZE*DATA_WIDTH-1:0] i_col;
    logic [ARRAY_SIZE-1:0]            w_row_valid;
    logic [NUM_PE*ACC_WIDTH-1:0]      acc_flat;

    // per-cell forwarded operands and sums
    logic signed [DATA_WIDTH-1:0] a_grid   [ARRAY_SIZE][ARRAY_SIZE];
    logic signed [DATA_WIDTH-1:0] b_grid   [ARRAY_SIZE][ARRAY_SIZE];
    logic                         v_grid   [ARRAY_SIZE][ARRAY_SIZE];
    logic signed [ACC_WIDTH-1:0]  acc_grid [ARRAY_SIZE][ARRAY_SIZE];

    sa_reg_file sa_reg_file_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_addr  (reg_addr),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .busy      (busy),
        .done_set  (done_set),
        .start     (start),
        .depth     (depth),
        .shift     (shift),
        .out_base  (out_base),
        .done      (done)
    );

    sa_controller sa_controller_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .depth       (depth),
        .data_rdy_in (data_rdy_in),
        .drain_busy  (drain_busy),
        .feed_en     (),
        .beat_valid  (beat_valid),
        .clr_acc     (clr_acc),
        .capture     (capture),
        .busy        (busy),
        .done_set    (done_set)
    );

    sa_skew_feeder sa_skew_feeder_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .clr_acc     (clr_acc),
        .beat_valid  (beat_valid),
        .w_vec       (w_vec),
        .i_vec       (i_vec),
        .w_row       (w_row),
        .w_row_valid (w_row_valid),
        .i_col       (i_col),
        .i_col_valid ()
    );

    for (genvar r = 0; r < ARRAY_SIZE; r++) begin : pe_row
        for (genvar c = 0; c < ARRAY_SIZE; c++) begin : pe_col
            logic signed [DATA_WIDTH-1:0] a_in;
            logic signed [DATA_WIDTH-1:0] b_in;
            logic                         v_in;

            // weights and valid enter on the left edge
            if (c == 0) begin : g_left
                assign a_in = w_row[r*DATA_WIDTH +: DATA_WIDTH];
                assign v_in = w_row_valid[r];
            end else begin : g_from_left
                assign a_in = a_grid[r][c-1];
                assign v_in = v_grid[r][c-1];
            end

            // inputs enter on the top edge
            if (r == 0) begin : g_top
                assign b_in = i_col[c*DATA_WIDTH +: DATA_WIDTH];
            end else begin : g_from_top
                assign b_in = b_grid[r-1][c];
            end

            sa_pe sa_pe_inst (
                .clk     (clk),
                .rst_n   (rst_n),
                .clr_acc (clr_acc),
                .a_in    (a_in),
                .b_in    (b_in),
                .v_in    (v_in),
                .a_out   (a_grid[r][c]),
                .b_out   (b_grid[r][c]),
                .v_out   (v_grid[r][c]),
                .acc     (acc_grid[r][c])
            );
        end
    end

    always_comb begin
        for (int r = 0; r < ARRAY_SIZE; r++) begin
            for (int c = 0; c < ARRAY_SIZE; c++) begin
                acc_flat[(r*ARRAY_SIZE + c)*ACC_WIDTH +: ACC_WIDTH] = acc_grid[r][c];
            end
        end
    end

    sa_drain sa_drain_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture    (capture),
        .acc_flat   (acc_flat),
        .shift      (shift),
        .out_base   (out_base),
        .out_valid  (out_valid),
        .out_addr   (out_addr),
        .out_data   (out_data),
        .drain_busy (drain_busy)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the systolic array testbench with verilator and run it
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sa_top -f tb.f -o tb_sa_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/tb_sa_top)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q '^>>> PASS$'; then
    exit 0
fi
exit 1

// File: tb.f
hdl/sa_array_pkg.sv
hdl/sa_cfg_pkg.sv
hdl/sa_reg_file.sv
hdl/sa_controller.sv
hdl/sa_skew_feeder.sv
hdl/sa_pe.sv
hdl/sa_drain.sv
hdl/sa_top.sv
dv/tb_sa_top.sv
